//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP = mips_pipeline_tb
FILELIST = mips_pipeline.f
OBJ_DIR = obj_dir

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@output="$$(./$(SIM))"; echo "$$output"; \
	echo "$$output" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/execution.sv
`default_nettype none

module execution #(
	parameter int INST_ADDR_WIDTH = 6
) (
	input  wire logic                       CLK,
	input  wire logic                       reset,
	input  wire logic                       id_valid,
	input  mips_pkg::alu_op_t               alu_op,
	input  wire logic                       use_imm,
	input  wire logic                       imm_zero_ext,
	input  wire logic                       reg_write,
	input  wire logic                       mem_read,
	input  wire logic                       mem_write,
	input  wire logic                       is_branch_eq,
	input  wire logic                       is_branch_ne,
	input  wire logic                       is_jump,
	input  wire logic                       is_out,
	input  wire logic                       is_halt,
	input  mips_pkg::reg_addr_t             dest,
	input  mips_pkg::reg_addr_t             rs,
	input  mips_pkg::reg_addr_t             rt,
	input  mips_pkg::word_t                 rs_value,
	input  mips_pkg::word_t                 rt_value,
	input  wire logic [15:0]                imm,
	input  wire logic [INST_ADDR_WIDTH-1:0] target,
	input  wire logic [INST_ADDR_WIDTH-1:0] id_pc,
	input  wire logic                       wb_write,
	input  mips_pkg::reg_addr_t             wb_dest,
	input  mips_pkg::word_t                 wb_data,
	output logic                            redirect,
	output logic [INST_ADDR_WIDTH-1:0]      redirect_pc,
	output logic                            ex_valid,
	output mips_pkg::word_t                 alu_result,
	output mips_pkg::word_t                 store_data,
	output mips_pkg::reg_addr_t             ex_dest,
	output logic                            ex_reg_write,
	output logic                            ex_mem_read,
	output logic                            ex_mem_write,
	output logic                            ex_is_out,
	output logic                            ex_is_halt
);

	mips_pkg::word_t op_a;
	mips_pkg::word_t op_b;
	mips_pkg::word_t imm_ext;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t result;
	logic [4:0] shamt;
	logic taken;
	logic [INST_ADDR_WIDTH-1:0] next_pc;

	// older results already reached decode through the register file
	assign op_a = (wb_write && wb_dest != '0 && wb_dest == rs) ? wb_data : rs_value;
	assign op_b = (wb_write && wb_dest != '0 && wb_dest == rt) ? wb_data : rt_value;

	assign imm_ext = imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
	assign alu_b = use_imm ? imm_ext : op_b;
	assign shamt = imm[10:6];

	always_comb begin
		case (alu_op)
			mips_pkg::ALU_ADD: result = op_a + alu_b;
			mips_pkg::ALU_SUB: result = op_a - alu_b;
			mips_pkg::ALU_AND: result = op_a & alu_b;
			mips_pkg::ALU_OR:  result = op_a | alu_b;
			mips_pkg::ALU_XOR: result = op_a ^ alu_b;
			mips_pkg::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(alu_b)};
			mips_pkg::ALU_SLL: result = alu_b << shamt;
			mips_pkg::ALU_SRL: result = alu_b >> shamt;
			mips_pkg::ALU_LUI: result = {alu_b[15:0], 16'b0};
			default:           result = op_a + alu_b;
		endcase
	end

	assign taken = is_jump || (is_branch_eq && op_a == op_b) ||
		(is_branch_ne && op_a != op_b);
	assign redirect = id_valid && taken;

	// branch offset counts words from pc+1
	assign next_pc = id_pc + 1'b1;
	assign redirect_pc = is_jump ? target : next_pc + imm[INST_ADDR_WIDTH-1:0];

	always_ff @(posedge CLK) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= id_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (id_valid) begin
			alu_result <= result;
			// out carries rs on the store data path
			store_data <= is_out ? op_a : op_b;
			ex_dest <= dest;
			ex_reg_write <= reg_write;
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
			ex_is_out <= is_out;
			ex_is_halt <= is_halt;
		end
	end

	// a taken branch leaves two bubbles behind it
	redirect_flush: assert property (@(posedge CLK) disable iff (reset)
		redirect |=> !id_valid ##1 !id_valid);

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
`default_nettype none

module inst_decode #(
	parameter int INST_ADDR_WIDTH = 6
) (
	input  wire logic                       CLK,
	input  wire logic                       reset,
	input  mips_pkg::word_t                 inst,
	input  wire logic [INST_ADDR_WIDTH-1:0] inst_pc,
	input  wire logic                       if_valid,
	input  wire logic                       redirect,
	input  wire logic                       wb_write,
	input  mips_pkg::reg_addr_t             wb_dest,
	input  mips_pkg::word_t                 wb_data,
	output logic                            fetch_stop,
	output logic                            id_valid,
	output mips_pkg::alu_op_t               alu_op,
	output logic                            use_imm,
	output logic                            imm_zero_ext,
	output logic                            reg_write,
	output logic                            mem_read,
	output logic                            mem_write,
	output logic                            is_branch_eq,
	output logic                            is_branch_ne,
	output logic                            is_jump,
	output logic                            is_out,
	output logic                            is_halt,
	output mips_pkg::reg_addr_t             dest,
	output mips_pkg::reg_addr_t             rs,
	output mips_pkg::reg_addr_t             rt,
	output mips_pkg::word_t                 rs_value,
	output mips_pkg::word_t                 rt_value,
	output logic [15:0]                     imm,
	output logic [INST_ADDR_WIDTH-1:0]      target,
	output logic [INST_ADDR_WIDTH-1:0]      id_pc
);

	mips_pkg::opcode_t opcode;
	mips_pkg::funct_t funct;
	mips_pkg::reg_addr_t rs_f;
	mips_pkg::reg_addr_t rt_f;
	mips_pkg::reg_addr_t rd_f;
	mips_pkg::word_t rs_read;
	mips_pkg::word_t rt_read;

	mips_pkg::alu_op_t dec_alu_op;
	mips_pkg::reg_addr_t dec_dest;
	logic dec_use_imm;
	logic dec_zero_ext;
	logic dec_reg_write;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_beq;
	logic dec_bne;
	logic dec_jump;
	logic dec_out;
	logic dec_halt;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];
	assign rs_f = inst[25:21];
	assign rt_f = inst[20:16];
	assign rd_f = inst[15:11];

	register_file register_file_i (
		.CLK(CLK),
		.reset(reset),
		.rs(rs_f),
		.rt(rt_f),
		.wb_write(wb_write),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.rs_value(rs_read),
		.rt_value(rt_read)
	);

	always_comb begin
		dec_alu_op = mips_pkg::ALU_ADD;
		dec_dest = rt_f;
		dec_use_imm = 1'b0;
		dec_zero_ext = 1'b0;
		dec_reg_write = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_beq = 1'b0;
		dec_bne = 1'b0;
		dec_jump = 1'b0;
		dec_out = 1'b0;
		dec_halt = 1'b0;
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				dec_dest = rd_f;
				dec_reg_write = 1'b1;
				case (funct)
					mips_pkg::FN_ADDU: dec_alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: dec_alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  dec_alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   dec_alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  dec_alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_SLT:  dec_alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLL:  dec_alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL:  dec_alu_op = mips_pkg::ALU_SRL;
					// unknown function acts as a nop
					default:           dec_reg_write = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDIU: begin
				dec_use_imm = 1'b1;
				dec_reg_write = 1'b1;
			end
			mips_pkg::OP_ORI: begin
				dec_alu_op = mips_pkg::ALU_OR;
				dec_use_imm = 1'b1;
				dec_zero_ext = 1'b1;
				dec_reg_write = 1'b1;
			end
			mips_pkg::OP_LUI: begin
				dec_alu_op = mips_pkg::ALU_LUI;
				dec_use_imm = 1'b1;
				dec_reg_write = 1'b1;
			end
			mips_pkg::OP_LW: begin
				dec_use_imm = 1'b1;
				dec_reg_write = 1'b1;
				dec_mem_read = 1'b1;
			end
			mips_pkg::OP_SW: begin
				dec_use_imm = 1'b1;
				dec_mem_write = 1'b1;
			end
			mips_pkg::OP_BEQ:  dec_beq = 1'b1;
			mips_pkg::OP_BNE:  dec_bne = 1'b1;
			mips_pkg::OP_J:    dec_jump = 1'b1;
			mips_pkg::OP_OUT:  dec_out = 1'b1;
			mips_pkg::OP_HALT: dec_halt = 1'b1;
			default: begin
			end
		endcase
	end

	// a halt flushed by an older branch must not stop fetch
	assign fetch_stop = if_valid && dec_halt && !redirect;

	always_ff @(posedge CLK) begin
		if (reset) begin
			id_valid <= 1'b0;
		end else begin
			id_valid <= if_valid && !redirect;
		end
	end

	always_ff @(posedge CLK) begin
		alu_op <= dec_alu_op;
		use_imm <= dec_use_imm;
		imm_zero_ext <= dec_zero_ext;
		reg_write <= dec_reg_write;
		mem_read <= dec_mem_read;
		mem_write <= dec_mem_write;
		is_branch_eq <= dec_beq;
		is_branch_ne <= dec_bne;
		is_jump <= dec_jump;
		is_out <= dec_out;
		is_halt <= dec_halt;
		dest <= dec_dest;
		rs <= rs_f;
		rt <= rt_f;
		rs_value <= rs_read;
		rt_value <= rt_read;
		// r-type keeps shamt in imm[10:6]
		imm <= inst[15:0];
		target <= inst[INST_ADDR_WIDTH-1:0];
		id_pc <= inst_pc;
	end

endmodule

`default_nettype wire

//--- hw/inst_fetch.sv
`default_nettype none

module inst_fetch #(
	parameter int INST_ADDR_WIDTH = 6
) (
	input  wire logic                       CLK,
	input  wire logic                       reset,
	input  wire logic                       load_valid,
	input  mips_pkg::word_t                 load_data,
	input  wire logic                       run,
	input  wire logic                       redirect,
	input  wire logic [INST_ADDR_WIDTH-1:0] redirect_pc,
	input  wire logic                       fetch_stop,
	output mips_pkg::word_t                 inst,
	output logic [INST_ADDR_WIDTH-1:0]      inst_pc,
	output logic                            if_valid
);

	mips_pkg::word_t imem [2**INST_ADDR_WIDTH];

	mips_pkg::run_state_t state;
	logic [INST_ADDR_WIDTH-1:0] load_addr;
	logic [INST_ADDR_WIDTH-1:0] pc;
	logic [INST_ADDR_WIDTH-1:0] fetch_addr;
	logic load_en;
	logic fetch_en;

	assign load_en = load_valid && state == mips_pkg::ST_IDLE;

	// the run strobe fetches word 0 in the same cycle
	assign fetch_en = (state == mips_pkg::ST_IDLE && run) ||
		(state == mips_pkg::ST_RUN && !fetch_stop && !redirect);
	assign fetch_addr = (state == mips_pkg::ST_IDLE) ? '0 : pc;

	always_ff @(posedge CLK) begin
		if (load_en) begin
			imem[load_addr] <= load_data;
		end
		if (fetch_en) begin
			inst <= imem[fetch_addr];
			inst_pc <= fetch_addr;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= mips_pkg::ST_IDLE;
			load_addr <= '0;
			pc <= '0;
			if_valid <= 1'b0;
		end else begin
			if_valid <= fetch_en;
			if (redirect) begin
				pc <= redirect_pc;
			end else if (fetch_en) begin
				pc <= fetch_addr + 1'b1;
			end
			case (state)
				mips_pkg::ST_IDLE: begin
					// loader counter wraps at the end of memory
					if (load_en) begin
						load_addr <= load_addr + 1'b1;
					end
					if (run) begin
						state <= mips_pkg::ST_RUN;
					end
				end
				mips_pkg::ST_RUN: begin
					if (fetch_stop) begin
						state <= mips_pkg::ST_HALT;
					end
				end
				default: begin
					state <= mips_pkg::ST_HALT;
				end
			endcase
		end
	end

	// programs are loaded only before run
	load_only_idle: assert property (@(posedge CLK) disable iff (reset)
		load_valid |-> state == mips_pkg::ST_IDLE);

endmodule

`default_nettype wire

//--- hw/memory_access.sv
`default_nettype none

module memory_access #(
	parameter int DATA_ADDR_WIDTH = 4
) (
	input  wire logic          CLK,
	input  wire logic          reset,
	input  wire logic          ex_valid,
	input  mips_pkg::word_t    alu_result,
	input  mips_pkg::word_t    store_data,
	input  mips_pkg::reg_addr_t ex_dest,
	input  wire logic          ex_reg_write,
	input  wire logic          ex_mem_read,
	input  wire logic          ex_mem_write,
	input  wire logic          ex_is_out,
	input  wire logic          ex_is_halt,
	output logic               wb_write,
	output mips_pkg::reg_addr_t wb_dest,
	output mips_pkg::word_t    wb_data,
	output logic               out_valid,
	output mips_pkg::word_t    out_data,
	output logic               halted
);

	mips_pkg::word_t dmem [2**DATA_ADDR_WIDTH];

	logic [DATA_ADDR_WIDTH-1:0] data_addr;
	mips_pkg::word_t load_data;
	logic halt_seen;

	// word address, wraps at the memory size
	assign data_addr = alu_result[DATA_ADDR_WIDTH+1:2];
	assign load_data = dmem[data_addr];

	always_ff @(posedge CLK) begin
		if (ex_valid && ex_mem_write) begin
			dmem[data_addr] <= store_data;
		end
	end

	assign wb_write = ex_valid && ex_reg_write;
	assign wb_dest = ex_dest;
	assign wb_data = ex_mem_read ? load_data : alu_result;

	assign out_valid = ex_valid && ex_is_out;
	assign out_data = store_data;

	always_ff @(posedge CLK) begin
		if (reset) begin
			halt_seen <= 1'b0;
		end else if (ex_valid && ex_is_halt) begin
			halt_seen <= 1'b1;
		end
	end

	// high from the halt's own writeback cycle
	assign halted = halt_seen || (ex_valid && ex_is_halt);

	no_read_and_write: assert property (@(posedge CLK) disable iff (reset)
		ex_valid |-> !(ex_mem_read && ex_mem_write));

endmodule

`default_nettype wire

//--- hw/mips_pipeline.sv
`default_nettype none

module mips_pipeline #(
	parameter int INST_ADDR_WIDTH = 6,
	parameter int DATA_ADDR_WIDTH = 4
) (
	input  wire logic       CLK,
	input  wire logic       reset,
	input  wire logic       load_valid,
	input  mips_pkg::word_t load_data,
	input  wire logic       run,
	output logic            out_valid,
	output mips_pkg::word_t out_data,
	output logic            halted
);

	// fetch
	mips_pkg::word_t inst;
	logic [INST_ADDR_WIDTH-1:0] inst_pc;
	logic if_valid;
	logic fetch_stop;

	// decode
	logic id_valid;
	mips_pkg::alu_op_t alu_op;
	logic use_imm;
	logic imm_zero_ext;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic is_branch_eq;
	logic is_branch_ne;
	logic is_jump;
	logic is_out;
	logic is_halt;
	mips_pkg::reg_addr_t dest;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::word_t rs_value;
	mips_pkg::word_t rt_value;
	logic [15:0] imm;
	logic [INST_ADDR_WIDTH-1:0] target;
	logic [INST_ADDR_WIDTH-1:0] id_pc;

	// execute
	logic redirect;
	logic [INST_ADDR_WIDTH-1:0] redirect_pc;
	logic ex_valid;
	mips_pkg::word_t alu_result;
	mips_pkg::word_t store_data;
	mips_pkg::reg_addr_t ex_dest;
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_is_out;
	logic ex_is_halt;

	// writeback
	logic wb_write;
	mips_pkg::reg_addr_t wb_dest;
	mips_pkg::word_t wb_data;

	inst_fetch #(
		.INST_ADDR_WIDTH(INST_ADDR_WIDTH)
	) inst_fetch_i (.*);

	inst_decode #(
		.INST_ADDR_WIDTH(INST_ADDR_WIDTH)
	) inst_decode_i (.*);

	execution #(
		.INST_ADDR_WIDTH(INST_ADDR_WIDTH)
	) execution_i (.*);

	memory_access #(
		.DATA_ADDR_WIDTH(DATA_ADDR_WIDTH)
	) memory_access_i (.*);

endmodule

`default_nettype wire

//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [3:0] alu_op_t;

	// primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_BNE   = 6'h05;
	localparam opcode_t OP_ADDIU = 6'h09;
	localparam opcode_t OP_ORI   = 6'h0d;
	localparam opcode_t OP_LUI   = 6'h0f;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;
	localparam opcode_t OP_OUT   = 6'h3e;
	localparam opcode_t OP_HALT  = 6'h3f;

	// r-type function codes
	localparam funct_t FN_SLL  = 6'h00;
	localparam funct_t FN_SRL  = 6'h02;
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_XOR  = 6'h26;
	localparam funct_t FN_SLT  = 6'h2a;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_SLT = 4'd5;
	localparam alu_op_t ALU_SLL = 4'd6;
	localparam alu_op_t ALU_SRL = 4'd7;
	localparam alu_op_t ALU_LUI = 4'd8;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_HALT
	} run_state_t;

endpackage

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

module register_file (
	input  wire logic         CLK,
	input  wire logic         reset,
	input  mips_pkg::reg_addr_t rs,
	input  mips_pkg::reg_addr_t rt,
	input  wire logic         wb_write,
	input  mips_pkg::reg_addr_t wb_dest,
	input  mips_pkg::word_t   wb_data,
	output mips_pkg::word_t   rs_value,
	output mips_pkg::word_t   rt_value
);

	mips_pkg::word_t regs [32];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_write && wb_dest != '0) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// write-through so decode sees the writeback in the same cycle
	assign rs_value = (rs == '0) ? '0 :
		(wb_write && wb_dest == rs) ? wb_data : regs[rs];
	assign rt_value = (rt == '0) ? '0 :
		(wb_write && wb_dest == rt) ? wb_data : regs[rt];

	// stage valids are clear by the second reset cycle
	no_write_in_reset: assert property (@(posedge CLK)
		reset && $past(reset) |-> !wb_write);

endmodule

`default_nettype wire

//--- mips_pipeline.f
hw/mips_pkg.sv
hw/inst_fetch.sv
hw/register_file.sv
hw/inst_decode.sv
hw/execution.sv
hw/memory_access.sv
hw/mips_pipeline.sv
test/mips_pipeline_tb.sv

//--- test/mips_pipeline_tb.sv
`default_nettype none

module mips_pipeline_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int HALT_HOLD_CYCLES = 10;
	localparam string VECTOR_FILE = "test/program_vectors.txt";

	logic CLK;
	logic reset;
	logic load_valid;
	mips_pkg::word_t load_data;
	logic run;
	logic out_valid;
	mips_pkg::word_t out_data;
	logic halted;

	string test_name;
	mips_pkg::word_t program_words [$];
	mips_pkg::word_t expected [$];
	int out_count;
	int tests_run;
	bit checking;

	mips_pipeline mips_pipeline_i (
		.CLK(CLK),
		.reset(reset),
		.load_valid(load_valid),
		.load_data(load_data),
		.run(run),
		.out_valid(out_valid),
		.out_data(out_data),
		.halted(halted)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// outputs are stable by the falling edge
	always @(negedge CLK) begin
		if (checking && out_valid) begin
			assert (!halted) else begin
				$display("test %s: out strobe seen after the core halted", test_name);
				abort_run();
			end
			assert (out_count < expected.size()) else begin
				$display("test %s: more outputs than expected, got %h", test_name, out_data);
				abort_run();
			end
			assert (out_data == expected[out_count]) else begin
				$display("FAIL %s expected %h actual %h", test_name, expected[out_count],
					out_data);
				abort_run();
			end
			out_count++;
		end
	end

	task automatic apply_reset();
		checking = 1'b0;
		@(posedge CLK);
		#2;
		reset = 1'b1;
		repeat (8) @(posedge CLK);
		#2;
		reset = 1'b0;
	endtask

	task automatic load_program();
		int idle;
		foreach (program_words[i]) begin
			idle = int'($urandom % 4);
			repeat (idle) begin
				@(posedge CLK);
				#2;
			end
			load_valid = 1'b1;
			load_data = program_words[i];
			@(posedge CLK);
			#2;
			load_valid = 1'b0;
		end
	endtask

	task automatic start_run();
		out_count = 0;
		checking = 1'b1;
		run = 1'b1;
		@(posedge CLK);
		#2;
		run = 1'b0;
	endtask

	task automatic wait_for_halt();
		int cycles;
		cycles = 0;
		while (!halted && cycles < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			#2;
			cycles++;
		end
		assert (halted) else begin
			$display("test %s: core did not halt within %0d cycles", test_name, TIMEOUT_CYCLES);
			abort_run();
		end
	endtask

	task automatic check_after_halt();
		assert (out_count == expected.size()) else begin
			$display("test %s: only %0d of %0d expected outputs seen before halt", test_name,
				out_count, expected.size());
			abort_run();
		end
		// late out strobes are caught by the monitor meanwhile
		repeat (HALT_HOLD_CYCLES) begin
			@(negedge CLK);
			assert (halted) else begin
				$display("test %s: halted dropped before reset", test_name);
				abort_run();
			end
		end
	endtask

	task automatic run_test();
		apply_reset();
		load_program();
		start_run();
		wait_for_halt();
		check_after_halt();
		$display("test %s: %0d outputs matched", test_name, out_count);
		tests_run++;
	endtask

	initial begin
		int fd;
		int code;
		bit pending;
		string tag;
		mips_pkg::word_t value;
		logic [8*200-1:0] rest_of_line;
		reset = 1'b1;
		load_valid = 1'b0;
		load_data = '0;
		run = 1'b0;
		checking = 1'b0;
		out_count = 0;
		tests_run = 0;
		pending = 1'b0;
		void'($urandom(32'h19e7fbc1));
		fd = $fopen(VECTOR_FILE, "r");
		assert (fd != 0) else begin
			$display("cannot open vector file %s", VECTOR_FILE);
			abort_run();
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "#") begin
				code = $fgets(rest_of_line, fd);
			end else if (tag == "T") begin
				// a new header closes the previous program
				if (pending) begin
					run_test();
				end
				program_words.delete();
				expected.delete();
				code = $fscanf(fd, "%s", test_name);
				pending = 1'b1;
			end else if (tag == "P" || tag == "E") begin
				code = $fscanf(fd, "%h", value);
				assert (code == 1 && pending) else begin
					$display("bad %s line in vector file", tag);
					abort_run();
				end
				if (tag == "P") begin
					program_words.push_back(value);
				end else begin
					expected.push_back(value);
				end
			end else begin
				$display("unknown tag %s in vector file", tag);
				abort_run();
			end
		end
		if (pending) begin
			run_test();
		end
		$fclose(fd);
		if (tests_run > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("no program found in vector file");
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- test/program_vectors.txt
# T name starts a program, P is one program word in hex from address 0
# E is the next expected out value in hex, in order
T alu
P 24010005
P 2422fffd
P 00411821
P 00612023
P 00042900
P 00a33025
P 00c13826
P 00e64024
P 00084842
P 0029502a
P 3c0b8000
P 356b1234
P 016a602a
P f9800000
P f8400000
P f8600000
P f8800000
P f8a00000
P f8c00000
P f8e00000
P f9000000
P f9200000
P f9400000
P f9600000
P fc000000
E 00000001
E 00000002
E 00000007
E 00000002
E 00000020
E 00000027
E 00000022
E 00000022
E 00000011
E 00000001
E 80001234
T memory
P 24010055
P 2402003c
P ac410044
P 8c030000
P 00632021
P f8800000
P ac040004
P 8c050004
P f8a00000
P f8600000
P fc000000
E 000000aa
E 000000aa
E 00000055
T branch
P 24010003
P 24020003
P 10220002
P f8200000
P f8400000
P 14220001
P f8200000
P 24030007
P 14230002
P fc000000
P f8600000
P 10230001
P f8600000
P fc000000
E 00000003
E 00000007
T loop
P 24010000
P 24020004
P 24210001
P f8200000
P 14220001
P fc000000
P 08000002
P f8400000
E 00000001
E 00000002
E 00000003
E 00000004
T halt
P 24000009
P f8000000
P 24010011
P f8200000
P fc000000
P f8200000
P f8200000
E 00000000
E 00000011
T reload
P f8200000
P 24030002
P f8600000
P fc000000
E 00000000
E 00000002
